/* Makefile */
SIM      = verilator
FLAGS    = --binary --assert --timing -Wno-fatal
TOP      = tb_write_splitter
FILELIST = sim.f
OBJ_DIR  = obj_dir

SRCS = $(shell cat $(FILELIST))
BIN  = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(OBJ_DIR)

/* addr_splitter.sv */
`timescale 1ns/1ps

module addr_splitter (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  splitter_pkg::addr_req_t req,
    output logic                    s_a_valid,
    input  logic                    s_a_ready,
    output splitter_pkg::addr_t     s_a_addr,
    output splitter_pkg::len_t      s_a_len,
    output logic                    seg_push,
    output splitter_pkg::beat_cnt_t seg_beats,
    input  logic                    seg_full
);

    typedef enum logic {
        st_idle,
        st_seg
    } state_t;

    state_t state;

    // residue of a request that crossed a page
    splitter_pkg::addr_t next_addr;
    splitter_pkg::len_t  rem_len;

    logic [splitter_pkg::PAGE_OFS_W-1:0] page_ofs;
    splitter_pkg::len_t                  first_room;
    logic                                first_fits;
    logic                                rem_fits;
    logic                                last_seg;
    splitter_pkg::len_t                  beat_span;

    // ------------------------------
    // segment cut
    // ------------------------------

    // bytes left in the page of the request address, 1..4096
    assign page_ofs   = req.addr[splitter_pkg::PAGE_OFS_W-1:0];
    assign first_room = splitter_pkg::len_t'(splitter_pkg::PAGE_SIZE)
                      - splitter_pkg::len_t'(page_ofs);
    assign first_fits = req.len <= first_room;
    assign rem_fits   = rem_len <= splitter_pkg::len_t'(splitter_pkg::PAGE_SIZE);

    always_comb begin
        if (state == st_idle) begin
            // head segment straight off the slice
            s_a_addr = req.addr;
            s_a_len  = first_fits ? req.len : first_room;
            last_seg = first_fits;
        end else begin
            // page aligned, full page or the tail
            s_a_addr = next_addr;
            s_a_len  = rem_fits ? rem_len : splitter_pkg::len_t'(splitter_pkg::PAGE_SIZE);
            last_seg = rem_fits;
        end
    end

    // hold off while the queue has no room for the beat count
    assign s_a_valid = (state == st_seg || req_valid) && !seg_full;
    assign seg_push  = s_a_valid && s_a_ready;

    // request retires with its final segment
    assign req_ready = seg_push && last_seg;

    // beats = ceil((addr mod 16 + len) / 16)
    assign beat_span = splitter_pkg::len_t'(s_a_addr[splitter_pkg::BUS_OFS_W-1:0])
                     + s_a_len
                     + splitter_pkg::len_t'(splitter_pkg::BUS_BYTES - 1);
    assign seg_beats = beat_span[splitter_pkg::BUS_OFS_W +: $bits(splitter_pkg::beat_cnt_t)];

    // ------------------------------
    // state
    // ------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else if (seg_push) begin
            state <= last_seg ? st_idle : st_seg;
        end
    end

    // residue bookkeeping, advances only on a pushed segment
    always_ff @(posedge clk) begin
        if (seg_push && !last_seg) begin
            next_addr <= s_a_addr + splitter_pkg::addr_t'(s_a_len);
            if (state == st_idle) begin
                rem_len <= req.len - first_room;
            end else begin
                rem_len <= rem_len - s_a_len;
            end
        end
    end

    // no segment leaves its page
    a_in_page : assert property (@(posedge clk) disable iff (!arst_n)
        seg_push |-> (int'(s_a_addr[splitter_pkg::PAGE_OFS_W-1:0]) + int'(s_a_len)
                      <= splitter_pkg::PAGE_SIZE));

endmodule

/* data_framer.sv */
`timescale 1ns/1ps

module data_framer (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    d_valid,
    output logic                    d_ready,
    input  splitter_pkg::data_t     d_data,
    input  logic                    seg_empty,
    input  splitter_pkg::beat_cnt_t seg_head,
    output logic                    seg_pop,
    output logic                    s_d_valid,
    input  logic                    s_d_ready,
    output splitter_pkg::data_t     s_d_data,
    output logic                    s_d_last
);

    // beats already sent for the head segment
    splitter_pkg::beat_cnt_t beat_cnt;
    logic                    at_last;
    logic                    beat_xfer;

    // ------------------------------
    // pass-through with framing
    // ------------------------------

    // this beat completes the head segment
    assign at_last = splitter_pkg::beat_cnt_t'(beat_cnt + 1'b1) == seg_head;

    // nothing moves until the address side has queued a segment
    assign s_d_valid = d_valid && !seg_empty;
    assign d_ready   = s_d_ready && !seg_empty;
    assign s_d_data  = d_data;
    assign s_d_last  = s_d_valid && at_last;

    assign beat_xfer = s_d_valid && s_d_ready;

    // segment done, drop its count
    assign seg_pop   = beat_xfer && at_last;

    // ------------------------------
    // beat counter
    // ------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            beat_cnt <= '0;
        end else if (beat_xfer) begin
            // restart for the next head
            if (at_last) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // count never runs past the queued segment length
    a_cnt_in_seg : assert property (@(posedge clk) disable iff (!arst_n)
        !seg_empty |-> beat_cnt < seg_head);

endmodule

/* reg_slice.sv */
`timescale 1ns/1ps

module reg_slice #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // main stage drives the output, skid catches the beat taken
    // while the output stalls
    logic     skid_valid;
    payload_t skid_data;
    logic     main_load;

    // main register free or draining this cycle
    assign main_load = out_ready || !out_valid;

    // ready straight from a flop, low only while skid is occupied
    assign in_ready = !skid_valid;

    // ------------------------------
    // control
    // ------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_load) begin
            // skid first, keeps order
            if (skid_valid) begin
                out_valid  <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                out_valid <= in_valid;
            end
        end else if (in_valid && in_ready) begin
            // output stalled, park the new beat
            skid_valid <= 1'b1;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (main_load) begin
            out_data <= skid_valid ? skid_data : in_data;
        end
        if (!skid_valid) begin
            skid_data <= in_data;
        end
    end

    // a stalled beat must stay put until taken
    a_out_stable : assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

/* seg_queue.sv */
`timescale 1ns/1ps

module seg_queue (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   seg_push,
    input  splitter_pkg::beat_cnt_t seg_beats,
    input  logic                   seg_pop,
    output splitter_pkg::beat_cnt_t seg_head,
    output logic                   seg_full,
    output logic                   seg_empty
);

    // beat count per segment, written by the address side
    splitter_pkg::beat_cnt_t mem [splitter_pkg::QUEUE_DEPTH];

    logic [splitter_pkg::QUEUE_PTR_W-1:0] wr_ptr;
    logic [splitter_pkg::QUEUE_PTR_W-1:0] rd_ptr;
    // one extra bit so full and empty differ
    logic [splitter_pkg::QUEUE_PTR_W:0]   count;

    assign seg_full  = count == (splitter_pkg::QUEUE_PTR_W + 1)'(splitter_pkg::QUEUE_DEPTH);
    assign seg_empty = count == '0;

    // head read straight from the array
    assign seg_head  = mem[rd_ptr];

    // ------------------------------
    // storage
    // ------------------------------
    always_ff @(posedge clk) begin
        if (seg_push) begin
            mem[wr_ptr] <= seg_beats;
        end
    end

    // pointers wrap at the power-of-two depth
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (seg_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (seg_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({seg_push, seg_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // producer and consumer sit in other modules
    a_no_overflow : assert property (@(posedge clk) disable iff (!arst_n)
        seg_push |-> !seg_full);
    a_no_underflow : assert property (@(posedge clk) disable iff (!arst_n)
        seg_pop |-> !seg_empty);

endmodule

/* sim.f */
splitter_pkg.sv
reg_slice.sv
seg_queue.sv
addr_splitter.sv
data_framer.sv
write_splitter.sv
tb_write_splitter.sv

/* splitter_pkg.sv */
package splitter_pkg;

    // ------------------------------
    // bus and page geometry
    // ------------------------------

    // byte address and request length
    localparam int ADDR_W      = 64;
    localparam int LEN_W       = 14;

    // 128-bit data bus, 16 bytes per beat
    localparam int DATA_W      = 128;
    localparam int BUS_BYTES   = 16;
    localparam int BUS_OFS_W   = 4;

    // 4 KiB pages, no segment may cross one
    localparam int PAGE_SIZE   = 4096;
    localparam int PAGE_OFS_W  = 12;

    // segment queue between address and data side
    localparam int QUEUE_DEPTH = 32;
    localparam int QUEUE_PTR_W = 5;

    // ------------------------------
    // types
    // ------------------------------
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [DATA_W-1:0] data_t;

    // up to 256 beats per page-bounded segment
    typedef logic [8:0]        beat_cnt_t;

    // address channel payload, addr in the upper bits
    typedef struct packed {
        addr_t addr;
        len_t  len;
    } addr_req_t;

endpackage

/* tb_write_splitter.sv */
`timescale 1ns/1ps

module tb_write_splitter;

    localparam int NUM_REQ = 8;

    logic                    clk;
    logic                    arst_n;
    logic                    a_valid;
    logic                    a_ready;
    splitter_pkg::addr_t     a_addr;
    splitter_pkg::len_t      a_len;
    logic                    d_valid;
    logic                    d_ready;
    splitter_pkg::data_t     d_data;
    logic                    s_a_valid;
    logic                    s_a_ready;
    splitter_pkg::addr_t     s_a_addr;
    splitter_pkg::len_t      s_a_len;
    logic                    s_d_valid;
    logic                    s_d_ready;
    splitter_pkg::data_t     s_d_data;
    logic                    s_d_last;

    // stimulus table, segments each request should yield
    splitter_pkg::addr_req_t req_tbl [NUM_REQ];
    int                      tbl_segs [NUM_REQ];

    // expected streams from the reference model
    splitter_pkg::addr_t     exp_addr [$];
    splitter_pkg::len_t      exp_len [$];
    int                      exp_a_req [$];
    int                      exp_beats [$];
    int                      exp_d_req [$];
    splitter_pkg::data_t     exp_data [$];
    splitter_pkg::data_t     send_data [$];
    splitter_pkg::data_t     word;

    // per-request bookkeeping
    int ref_segs [NUM_REQ];
    int req_beats [NUM_REQ];
    int seg_seen [NUM_REQ];
    int segs_done [NUM_REQ];
    int req_err [NUM_REQ];

    int seed = 32'h6a17_19d5;
    int a_idx = 0;
    int d_idx = 0;
    logic a_fire = 1'b0;
    logic d_fire = 1'b0;
    logic run = 1'b0;
    int beat_in_seg = 0;
    int last_cnt = 0;
    int total_beats = 0;
    int total_segs = 0;
    int errors = 0;
    int checks = 0;
    int tests_done = 0;
    int tests_failed = 0;
    int cycles = 0;
    int cycle_limit = 0;

    write_splitter dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------
    // reference model
    // ------------------------------
    task automatic set_entry(input int idx, input splitter_pkg::addr_t addr,
                             input int len, input int nseg);
        req_tbl[idx].addr = addr;
        req_tbl[idx].len  = splitter_pkg::len_t'(len);
        tbl_segs[idx]     = nseg;
    endtask

    // head runs to the page end, then whole pages, then the rest
    task automatic cut_request(input int idx);
        longint unsigned cur;
        int rem;
        int room;
        int seg;
        int beats;
        cur = req_tbl[idx].addr;
        rem = int'(req_tbl[idx].len);
        while (rem > 0) begin
            room  = splitter_pkg::PAGE_SIZE - int'(cur % 64'(splitter_pkg::PAGE_SIZE));
            seg   = (rem < room) ? rem : room;
            beats = (int'(cur % 64'(splitter_pkg::BUS_BYTES)) + seg
                     + splitter_pkg::BUS_BYTES - 1) / splitter_pkg::BUS_BYTES;
            exp_addr.push_back(cur);
            exp_len.push_back(splitter_pkg::len_t'(seg));
            exp_a_req.push_back(idx);
            exp_beats.push_back(beats);
            exp_d_req.push_back(idx);
            ref_segs[idx]  += 1;
            req_beats[idx] += beats;
            cur += 64'(seg);
            rem -= seg;
        end
    endtask

    // ------------------------------
    // checkers
    // ------------------------------
    task automatic finish_test(input int r);
        checks++;
        assert (seg_seen[r] == tbl_segs[r]) else begin
            $display("FAIL %0t ns: test %0d gave %0d segments, expected %0d",
                     $time, r, seg_seen[r], tbl_segs[r]);
            errors++;
            req_err[r]++;
        end
        tests_done++;
        if (req_err[r] != 0) begin
            tests_failed++;
        end
        $display("test %0d: 0x%h + %0d bytes, %0d segments, %0d beats, %0d errors",
                 r, req_tbl[r].addr, req_tbl[r].len, seg_seen[r], req_beats[r], req_err[r]);
    endtask

    task automatic check_segment();
        int r;
        checks++;
        assert (exp_addr.size() > 0) else begin
            $display("FAIL %0t ns: segment 0x%h len %0d was not expected",
                     $time, s_a_addr, s_a_len);
            errors++;
        end
        if (exp_addr.size() > 0) begin
            r = exp_a_req.pop_front();
            assert (s_a_addr == exp_addr[0] && s_a_len == exp_len[0]) else begin
                $display("FAIL %0t ns: test %0d segment 0x%h len %0d, expected 0x%h len %0d",
                         $time, r, s_a_addr, s_a_len, exp_addr[0], exp_len[0]);
                errors++;
                req_err[r]++;
            end
            void'(exp_addr.pop_front());
            void'(exp_len.pop_front());
            seg_seen[r]++;
        end
    endtask

    task automatic check_beat();
        int   r;
        logic exp_last;
        checks++;
        assert (exp_beats.size() > 0 && exp_data.size() > 0) else begin
            $display("FAIL %0t ns: data beat arrived with no segment left to carry it", $time);
            errors++;
        end
        if (exp_beats.size() > 0 && exp_data.size() > 0) begin
            r        = exp_d_req[0];
            exp_last = (beat_in_seg + 1 == exp_beats[0]);
            assert (s_d_data == exp_data[0]) else begin
                $display("FAIL %0t ns: test %0d data 0x%h, expected 0x%h",
                         $time, r, s_d_data, exp_data[0]);
                errors++;
                req_err[r]++;
            end
            assert (s_d_last == exp_last) else begin
                $display("FAIL %0t ns: test %0d last %b on beat %0d of %0d",
                         $time, r, s_d_last, beat_in_seg + 1, exp_beats[0]);
                errors++;
                req_err[r]++;
            end
            void'(exp_data.pop_front());
            if (s_d_last) begin
                last_cnt++;
            end
            if (exp_last) begin
                beat_in_seg = 0;
                void'(exp_beats.pop_front());
                void'(exp_d_req.pop_front());
                segs_done[r]++;
                if (segs_done[r] == ref_segs[r]) begin
                    finish_test(r);
                end
            end else begin
                beat_in_seg++;
            end
        end
    endtask

    // handshakes sampled mid-cycle where everything is settled
    always @(negedge clk) begin
        a_fire = a_valid && a_ready;
        d_fire = d_valid && d_ready;
        if (arst_n && s_a_valid && s_a_ready) begin
            check_segment();
        end
        if (arst_n && s_d_valid && s_d_ready) begin
            check_beat();
        end
    end

    // ------------------------------
    // drivers
    // ------------------------------
    always @(posedge clk) begin
        if (run) begin
            if (a_fire) begin
                a_idx = a_idx + 1;
            end
            if (d_fire) begin
                d_idx = d_idx + 1;
            end
            // valid held with its payload until taken
            if (a_idx < NUM_REQ) begin
                a_valid <= 1'b1;
                a_addr  <= req_tbl[a_idx].addr;
                a_len   <= req_tbl[a_idx].len;
            end else begin
                a_valid <= 1'b0;
            end
            if (d_idx < send_data.size()) begin
                d_valid <= 1'b1;
                d_data  <= send_data[d_idx];
            end else begin
                d_valid <= 1'b0;
            end
            // random back-pressure, ready about 3 cycles in 4
            s_a_ready <= ($random(seed) & 3) != 0;
            s_d_ready <= ($random(seed) & 3) != 0;
        end
    end

    // run limit scaled to the expected traffic
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout at cycle %0d with %0d segments and %0d data beats still pending",
                     cycles, exp_addr.size(), exp_data.size());
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        arst_n    = 1'b0;
        a_valid   = 1'b0;
        a_addr    = '0;
        a_len     = '0;
        d_valid   = 1'b0;
        d_data    = '0;
        s_a_ready = 1'b0;
        s_d_ready = 1'b0;

        // inside a page, one boundary, long unaligned, then mixed
        set_entry(0, 64'h0000_0000_0000_0100, 64, 1);
        set_entry(1, 64'h0000_0000_0000_0ff8, 32, 2);
        set_entry(2, 64'h0000_0001_0000_0f00, 10000, 4);
        set_entry(3, 64'h0000_0000_0000_0000, 1, 1);
        set_entry(4, 64'h0000_0000_0000_2fff, 16383, 5);
        set_entry(5, 64'h0000_0003_0000_1000, 4096, 1);
        set_entry(6, 64'h0000_0007_ffff_f7f1, 3000, 2);
        set_entry(7, 64'h1234_5678_9abc_def3, 16, 1);

        for (int i = 0; i < NUM_REQ; i++) begin
            cut_request(i);
            total_beats += req_beats[i];
        end
        total_segs = exp_addr.size();
        for (int i = 0; i < total_beats; i++) begin
            for (int k = 0; k < 4; k++) begin
                word[k*32 +: 32] = $random(seed);
            end
            send_data.push_back(word);
            exp_data.push_back(word);
        end
        cycle_limit = 8 * (total_beats + total_segs) + 200;

        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        checks++;
        assert (!s_a_valid && !s_d_valid) else begin
            $display("FAIL %0t ns: outputs not idle after reset", $time);
            errors++;
            tests_failed++;
        end
        $display("test reset: s_a_valid %b, s_d_valid %b", s_a_valid, s_d_valid);
        run = 1'b1;

        wait (tests_done == NUM_REQ);
        repeat (4) @(posedge clk);
        checks++;
        assert (last_cnt == total_segs && exp_addr.size() == 0 && exp_data.size() == 0)
        else begin
            $display("FAIL %0t ns: %0d last flags for %0d segments, %0d segments left",
                     $time, last_cnt, total_segs, exp_addr.size());
            errors++;
        end
        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 NUM_REQ + 1, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* write_splitter.sv */
`timescale 1ns/1ps

module write_splitter (
    input  logic                clk,
    input  logic                arst_n,
    // upstream address
    input  logic                a_valid,
    output logic                a_ready,
    input  splitter_pkg::addr_t a_addr,
    input  splitter_pkg::len_t  a_len,
    // upstream data
    input  logic                d_valid,
    output logic                d_ready,
    input  splitter_pkg::data_t d_data,
    // downstream address
    output logic                s_a_valid,
    input  logic                s_a_ready,
    output splitter_pkg::addr_t s_a_addr,
    output splitter_pkg::len_t  s_a_len,
    // downstream data
    output logic                s_d_valid,
    input  logic                s_d_ready,
    output splitter_pkg::data_t s_d_data,
    output logic                s_d_last
);

    // ------------------------------
    // internal wires
    // ------------------------------
    splitter_pkg::addr_req_t a_req_in;
    splitter_pkg::addr_req_t req;
    logic                    req_valid;
    logic                    req_ready;

    splitter_pkg::data_t     dr_data;
    logic                    dr_valid;
    logic                    dr_ready;

    // segment queue handshake
    logic                    seg_push;
    logic                    seg_pop;
    logic                    seg_full;
    logic                    seg_empty;
    splitter_pkg::beat_cnt_t seg_beats;
    splitter_pkg::beat_cnt_t seg_head;

    assign a_req_in = '{addr: a_addr, len: a_len};

    // ------------------------------
    // instances
    // ------------------------------

    // address channel input stage
    reg_slice #(
        .payload_t (splitter_pkg::addr_req_t)
    ) addr_slice_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (a_valid),
        .in_ready  (a_ready),
        .in_data   (a_req_in),
        .out_valid (req_valid),
        .out_ready (req_ready),
        .out_data  (req)
    );

    // data channel input stage
    reg_slice #(
        .payload_t (splitter_pkg::data_t)
    ) data_slice_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (d_valid),
        .in_ready  (d_ready),
        .in_data   (d_data),
        .out_valid (dr_valid),
        .out_ready (dr_ready),
        .out_data  (dr_data)
    );

    addr_splitter addr_splitter_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .s_a_valid (s_a_valid),
        .s_a_ready (s_a_ready),
        .s_a_addr  (s_a_addr),
        .s_a_len   (s_a_len),
        .seg_push  (seg_push),
        .seg_beats (seg_beats),
        .seg_full  (seg_full)
    );

    // beat counts cross from address side to data side here
    seg_queue seg_queue_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .seg_push  (seg_push),
        .seg_beats (seg_beats),
        .seg_pop   (seg_pop),
        .seg_head  (seg_head),
        .seg_full  (seg_full),
        .seg_empty (seg_empty)
    );

    data_framer data_framer_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .d_valid   (dr_valid),
        .d_ready   (dr_ready),
        .d_data    (dr_data),
        .seg_empty (seg_empty),
        .seg_head  (seg_head),
        .seg_pop   (seg_pop),
        .s_d_valid (s_d_valid),
        .s_d_ready (s_d_ready),
        .s_d_data  (s_d_data),
        .s_d_last  (s_d_last)
    );

endmodule
